// ==== source/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN            = 32;
    localparam int REG_ADDR_W      = 5;
    localparam int IN_DEPTH        = 4;
    localparam int OUT_CREDITS_MAX = 4;
    localparam int IN_PTR_W        = $clog2(IN_DEPTH);
    localparam int OUT_CREDIT_W    = $clog2(OUT_CREDITS_MAX + 1);

    //////////////////////////////
    // Opcode fields

    // Three-register and shift-immediate formats, bits 31:15
    localparam logic [16:0] OP17_ADD  = 17'h00020;
    localparam logic [16:0] OP17_SUB  = 17'h00022;
    localparam logic [16:0] OP17_SLT  = 17'h00024;
    localparam logic [16:0] OP17_SLTU = 17'h00025;
    localparam logic [16:0] OP17_NOR  = 17'h00028;
    localparam logic [16:0] OP17_AND  = 17'h00029;
    localparam logic [16:0] OP17_OR   = 17'h0002a;
    localparam logic [16:0] OP17_XOR  = 17'h0002b;
    localparam logic [16:0] OP17_SLL  = 17'h0002e;
    localparam logic [16:0] OP17_SRL  = 17'h0002f;
    localparam logic [16:0] OP17_SRA  = 17'h00030;
    localparam logic [16:0] OP17_SLLI = 17'h00081;
    localparam logic [16:0] OP17_SRLI = 17'h00089;
    localparam logic [16:0] OP17_SRAI = 17'h00091;

    // 12-bit immediate format, bits 31:22
    localparam logic [9:0] OP10_ADDI  = 10'h00a;
    localparam logic [9:0] OP10_SLTI  = 10'h008;
    localparam logic [9:0] OP10_SLTUI = 10'h009;
    localparam logic [9:0] OP10_ANDI  = 10'h00d;
    localparam logic [9:0] OP10_ORI   = 10'h00e;
    localparam logic [9:0] OP10_XORI  = 10'h00f;

    localparam logic [6:0] OP7_LU12I  = 7'h0a;

    //////////////////////////////
    // Types

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_NONE = 5'h1f
    } alu_op_e;

    typedef struct packed {
        logic [16:0]           op;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]            op;
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [6:0]            op;
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_ri20_t;

    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri20_t ri20;
    } instr_u;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  illegal;
        logic                  valid;
    } uop_t;

    typedef struct packed {
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } operands_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  illegal;
        logic                  write;
    } wb_t;

endpackage

// ==== source/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl import isa_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   in_valid,
    input  instr_u in_word,
    input  logic   res_credit,
    output logic   issue,
    output instr_u issue_word,
    output logic   in_credit
);

    instr_u                fifo_mem [IN_DEPTH];
    logic [IN_PTR_W-1:0]   wr_ptr;
    logic [IN_PTR_W-1:0]   rd_ptr;
    logic [IN_PTR_W:0]     count;
    logic [OUT_CREDIT_W-1:0] out_credits;
    logic                  fifo_empty;

    assign fifo_empty = (count == '0);

    // Head goes out only when a result slot is already granted
    assign issue      = !fifo_empty && (out_credits != '0);
    assign issue_word = fifo_mem[rd_ptr];

    //////////////////////////////
    // Input FIFO

    // Sender never overruns its credits, so no full check
    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (IN_PTR_W + 1)'(in_valid) - (IN_PTR_W + 1)'(issue);
        end
    end

    //////////////////////////////
    // Credits

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_credits <= '0;
            in_credit   <= 1'b0;
        end else begin
            out_credits <= out_credits + OUT_CREDIT_W'(res_credit) - OUT_CREDIT_W'(issue);
            // One freed slot per issue, returned a cycle later
            in_credit   <= issue;
        end
    end

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode import isa_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   issue,
    input  instr_u issue_word,
    output uop_t   uop
);

    uop_t dec;

    always_comb begin
        dec         = '0;
        dec.valid   = 1'b1;
        dec.rd      = issue_word.r3.rd;
        dec.alu_op  = ALU_NONE;

        // Register and shift-immediate forms
        case (issue_word.r3.op)
            OP17_ADD:  dec.alu_op = ALU_ADD;
            OP17_SUB:  dec.alu_op = ALU_SUB;
            OP17_SLT:  dec.alu_op = ALU_SLT;
            OP17_SLTU: dec.alu_op = ALU_SLTU;
            OP17_AND:  dec.alu_op = ALU_AND;
            OP17_OR:   dec.alu_op = ALU_OR;
            OP17_NOR:  dec.alu_op = ALU_NOR;
            OP17_XOR:  dec.alu_op = ALU_XOR;
            OP17_SLL, OP17_SLLI: dec.alu_op = ALU_SLL;
            OP17_SRL, OP17_SRLI: dec.alu_op = ALU_SRL;
            OP17_SRA, OP17_SRAI: dec.alu_op = ALU_SRA;
            default: ;
        endcase
        if (issue_word.r3.op inside {OP17_SLLI, OP17_SRLI, OP17_SRAI}) begin
            // Shift amount sits where rk would be
            dec.use_imm = 1'b1;
            dec.imm     = {{(XLEN - REG_ADDR_W){1'b0}}, issue_word.r3.rk};
        end

        case (issue_word.ri12.op)
            OP10_ADDI:  dec.alu_op = ALU_ADD;
            OP10_SLTI:  dec.alu_op = ALU_SLT;
            OP10_SLTUI: dec.alu_op = ALU_SLTU;
            OP10_ANDI:  dec.alu_op = ALU_AND;
            OP10_ORI:   dec.alu_op = ALU_OR;
            OP10_XORI:  dec.alu_op = ALU_XOR;
            default: ;
        endcase
        case (issue_word.ri12.op)
            OP10_ADDI, OP10_SLTI, OP10_SLTUI: begin
                dec.use_imm = 1'b1;
                dec.imm     = {{(XLEN - 12){issue_word.ri12.imm[11]}}, issue_word.ri12.imm};
            end
            OP10_ANDI, OP10_ORI, OP10_XORI: begin
                dec.use_imm = 1'b1;
                dec.imm     = {{(XLEN - 12){1'b0}}, issue_word.ri12.imm};
            end
            default: ;
        endcase

        if (issue_word.ri20.op == OP7_LU12I) begin
            dec.alu_op  = ALU_LUI;
            dec.use_imm = 1'b1;
            dec.imm     = {issue_word.ri20.imm, 12'b0};
        end

        dec.illegal = (dec.alu_op == ALU_NONE);
    end

    // Idle cycles become bubbles
    always_ff @(posedge clk) begin
        if (!rstn || !issue) begin
            uop <= '0;
        end else begin
            uop <= dec;
        end
    end

endmodule

// ==== source/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch import isa_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      issue,
    input  instr_u    issue_word,
    input  wb_t       wb,
    output operands_t ops
);

    logic [XLEN-1:0]       regs [2**REG_ADDR_W];
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       rj_val;
    logic [XLEN-1:0]       rk_val;
    logic [REG_ADDR_W-1:0] rj_q;
    logic [REG_ADDR_W-1:0] rk_q;
    logic [XLEN-1:0]       src1_q;
    logic [XLEN-1:0]       src2_q;

    //////////////////////////////
    // Register file

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    assign rj = issue_word.r3.rj;
    assign rk = issue_word.r3.rk;

    // Write-through covers the result being written this cycle
    assign rj_val = (rj == '0) ? '0 : (wb.write && wb.rd == rj) ? wb.value : regs[rj];
    assign rk_val = (rk == '0) ? '0 : (wb.write && wb.rd == rk) ? wb.value : regs[rk];

    always_ff @(posedge clk) begin
        if (issue) begin
            rj_q   <= rj;
            rk_q   <= rk;
            src1_q <= rj_val;
            src2_q <= rk_val;
        end
    end

    // Bypass from the result of the previous instruction
    always_comb begin
        ops.src1 = src1_q;
        ops.src2 = src2_q;
        if (wb.write && rj_q != '0 && wb.rd == rj_q) begin
            ops.src1 = wb.value;
        end
        if (wb.write && rk_q != '0 && wb.rd == rk_q) begin
            ops.src2 = wb.value;
        end
    end

endmodule

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu import isa_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  uop_t      uop,
    input  operands_t ops,
    output wb_t       wb,
    output logic      res_valid
);

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign op_b  = uop.use_imm ? uop.imm : ops.src2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (uop.alu_op)
            ALU_ADD:  result = ops.src1 + op_b;
            ALU_SUB:  result = ops.src1 - op_b;
            ALU_SLT:  result = {{(XLEN - 1){1'b0}}, $signed(ops.src1) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN - 1){1'b0}}, ops.src1 < op_b};
            ALU_AND:  result = ops.src1 & op_b;
            ALU_OR:   result = ops.src1 | op_b;
            ALU_NOR:  result = ~(ops.src1 | op_b);
            ALU_XOR:  result = ops.src1 ^ op_b;
            ALU_SLL:  result = ops.src1 << shamt;
            ALU_SRL:  result = ops.src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(ops.src1) >>> shamt);
            ALU_LUI:  result = op_b;
            default:  result = '0;
        endcase
    end

    //////////////////////////////
    // Writeback register

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res_valid <= 1'b0;
            wb.write  <= 1'b0;
        end else begin
            res_valid <= uop.valid;
            wb.write  <= uop.valid && !uop.illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd      <= uop.rd;
        wb.value   <= result;
        wb.illegal <= uop.illegal;
    end

endmodule

// ==== source/exec_core.sv ====
`timescale 1ns/1ps

module exec_core import isa_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   in_valid,
    input  instr_u in_word,
    input  logic   res_credit,
    output logic   in_credit,
    output logic   res_valid,
    output wb_t    res
);

    logic      issue;
    instr_u    issue_word;
    uop_t      uop;
    operands_t ops;
    wb_t       wb;

    issue_ctrl u_issue_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .res_credit (res_credit),
        .issue      (issue),
        .issue_word (issue_word),
        .in_credit  (in_credit)
    );

    // Decode and operand fetch see the same word at the same edge
    inst_decode u_inst_decode (
        .clk        (clk),
        .rstn       (rstn),
        .issue      (issue),
        .issue_word (issue_word),
        .uop        (uop)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .rstn       (rstn),
        .issue      (issue),
        .issue_word (issue_word),
        .wb         (wb),
        .ops        (ops)
    );

    exec_alu u_exec_alu (
        .clk        (clk),
        .rstn       (rstn),
        .uop        (uop),
        .ops        (ops),
        .wb         (wb),
        .res_valid  (res_valid)
    );

    assign res = wb;

endmodule

// ==== bench/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import isa_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   in_valid,
    input  instr_u in_word,
    input  logic   in_credit,
    input  logic   res_credit,
    input  logic   res_valid,
    input  wb_t    res,
    input  logic   end_test,
    output int     pending,
    output int     checked,
    output int     value_errors,
    output int     proto_errors,
    output logic   checks_done
);

    logic [XLEN-1:0] model_regs [2**REG_ADDR_W];
    wb_t             expected_q [$];
    int              words_in;
    int              results;
    int              grants;
    int              credit_pulses;

    //////////////////////////////
    // Reference model

    // Sequential semantics, one word at a time
    function automatic wb_t model_exec(input instr_u w);
        wb_t             r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] se12;
        logic [XLEN-1:0] ze12;
        a    = model_regs[w.r3.rj];
        b    = model_regs[w.r3.rk];
        se12 = {{20{w.ri12.imm[11]}}, w.ri12.imm};
        ze12 = {20'b0, w.ri12.imm};
        r       = '0;
        r.rd    = w.r3.rd;
        r.write = 1'b1;
        if (w.ri20.op == OP7_LU12I) begin
            r.value = {w.ri20.imm, 12'b0};
        end else if (w.ri12.op inside {OP10_ADDI, OP10_SLTI, OP10_SLTUI,
                                       OP10_ANDI, OP10_ORI, OP10_XORI}) begin
            case (w.ri12.op)
                OP10_ADDI:  r.value = a + se12;
                OP10_SLTI:  r.value = {31'b0, $signed(a) < $signed(se12)};
                OP10_SLTUI: r.value = {31'b0, a < se12};
                OP10_ANDI:  r.value = a & ze12;
                OP10_ORI:   r.value = a | ze12;
                default:    r.value = a ^ ze12;
            endcase
        end else begin
            case (w.r3.op)
                OP17_ADD:  r.value = a + b;
                OP17_SUB:  r.value = a - b;
                OP17_SLT:  r.value = {31'b0, $signed(a) < $signed(b)};
                OP17_SLTU: r.value = {31'b0, a < b};
                OP17_AND:  r.value = a & b;
                OP17_OR:   r.value = a | b;
                OP17_NOR:  r.value = ~(a | b);
                OP17_XOR:  r.value = a ^ b;
                OP17_SLL:  r.value = a << b[4:0];
                OP17_SRL:  r.value = a >> b[4:0];
                OP17_SRA:  r.value = $signed(a) >>> b[4:0];
                OP17_SLLI: r.value = a << w.r3.rk;
                OP17_SRLI: r.value = a >> w.r3.rk;
                OP17_SRAI: r.value = $signed(a) >>> w.r3.rk;
                default: begin
                    r.illegal = 1'b1;
                    r.write   = 1'b0;
                end
            endcase
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    //////////////////////////////
    // Monitor

    always @(posedge clk) begin
        wb_t exp_wb;
        if (!rstn) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                model_regs[i] = '0;
            end
            expected_q.delete();
            words_in      = 0;
            results       = 0;
            grants        = 0;
            credit_pulses = 0;
            pending       = 0;
            checked       = 0;
            value_errors  = 0;
            proto_errors  = 0;
            checks_done   = 1'b0;
        end else begin
            if (words_in == 0 && (res_valid || in_credit)) begin
                proto_errors++;
                $display("Error: DUT output went high before any word was sent");
            end
            if (res_valid) begin
                results++;
                if (results > grants) begin
                    proto_errors++;
                    $display("Error: result %0d came out without an output credit", results);
                end
                if (expected_q.size() == 0) begin
                    proto_errors++;
                    $display("Error: result came out with no word outstanding");
                end else begin
                    exp_wb = expected_q.pop_front();
                    check_field($sformatf("instr %0d rd", checked), 32'(exp_wb.rd),
                                32'(res.rd));
                    check_field($sformatf("instr %0d illegal", checked),
                                32'(exp_wb.illegal), 32'(res.illegal));
                    check_field($sformatf("instr %0d write", checked), 32'(exp_wb.write),
                                32'(res.write));
                    if (!exp_wb.illegal) begin
                        check_field($sformatf("instr %0d value", checked), exp_wb.value,
                                    res.value);
                    end
                    checked++;
                end
            end
            if (in_valid) begin
                exp_wb = model_exec(in_word);
                // r0 keeps reading as zero
                if (exp_wb.write && exp_wb.rd != '0) begin
                    model_regs[exp_wb.rd] = exp_wb.value;
                end
                expected_q.push_back(exp_wb);
                words_in++;
            end
            if (res_credit) begin
                grants++;
            end
            if (in_credit) begin
                credit_pulses++;
            end
            pending = expected_q.size();
            if (end_test && !checks_done) begin
                if (credit_pulses != words_in) begin
                    proto_errors++;
                    $display("Error: %0d in_credit pulses for %0d accepted words",
                             credit_pulses, words_in);
                end
                if (results != words_in) begin
                    proto_errors++;
                    $display("Error: %0d results for %0d accepted words", results, words_in);
                end
                checks_done = 1'b1;
            end
        end
    end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import isa_pkg::*; ();

    localparam int N_INSTR     = 400;
    localparam int SEND_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 500;
    localparam int DONE_LIMIT  = 20;

    logic        clk;
    logic        rstn;
    logic        in_valid;
    instr_u      in_word;
    logic        res_credit;
    logic        in_credit;
    logic        res_valid;
    wb_t         res;
    logic        end_test;
    logic        checks_done;
    int          pending;
    int          checked;
    int          value_errors;
    int          proto_errors;

    logic [31:0] lfsr_state;
    logic        timed_out;
    int          sent;
    int          in_credits;
    int          open_credits;
    int          cycles;
    logic [16:0] r3_ops [14];
    logic [9:0]  ri12_ops [6];

    always #2 clk = ~clk;

    exec_core u_exec_core (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .res_credit (res_credit),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

    tb_checker u_checker (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .in_credit    (in_credit),
        .res_credit   (res_credit),
        .res_valid    (res_valid),
        .res          (res),
        .end_test     (end_test),
        .pending      (pending),
        .checked      (checked),
        .value_errors (value_errors),
        .proto_errors (proto_errors),
        .checks_done  (checks_done)
    );

    //////////////////////////////
    // Random source

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return val;
    endfunction

    // Registers limited to r0..r7 so dependencies are frequent
    task automatic make_word(output instr_u w);
        logic [31:0] bits;
        logic [31:0] rd;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] imm;
        int          kind;
        bits = draw_bits(5);
        kind = int'(bits % 24);
        rd   = draw_bits(3);
        rj   = draw_bits(3);
        rk   = draw_bits(3);
        imm  = draw_bits(20);
        w = '0;
        if (kind < 11) begin
            w.r3 = '{r3_ops[kind], rk[4:0], rj[4:0], rd[4:0]};
        end else if (kind < 14) begin
            w.r3 = '{r3_ops[kind], imm[4:0], rj[4:0], rd[4:0]};
        end else if (kind < 20) begin
            w.ri12 = '{ri12_ops[kind - 14], imm[11:0], rj[4:0], rd[4:0]};
        end else if (kind < 22) begin
            w.ri20 = '{OP7_LU12I, imm[19:0], rd[4:0]};
        end else begin
            // No format has an opcode in this range
            w = {8'hff, imm[18:0], rd[4:0]};
        end
    endtask

    //////////////////////////////
    // Sender and receiver

    task automatic run_cycle(input logic may_send);
        logic [31:0] r;
        instr_u      w;
        @(posedge clk);
        #1;
        if (in_credit) begin
            in_credits++;
        end
        if (res_valid) begin
            open_credits--;
        end
        in_valid   = 1'b0;
        res_credit = 1'b0;
        if (may_send && sent < N_INSTR && in_credits > 0) begin
            r = draw_bits(2);
            if (r[1:0] != 2'b00) begin
                make_word(w);
                in_word    = w;
                in_valid   = 1'b1;
                in_credits--;
                sent++;
            end
        end
        if (open_credits < OUT_CREDITS_MAX) begin
            r = draw_bits(1);
            if (r[0]) begin
                res_credit = 1'b1;
                open_credits++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        in_valid     = 1'b0;
        in_word      = '0;
        res_credit   = 1'b0;
        end_test     = 1'b0;
        lfsr_state   = 32'd32;
        timed_out    = 1'b0;
        sent         = 0;
        in_credits   = IN_DEPTH;
        open_credits = 0;
        r3_ops   = '{OP17_ADD, OP17_SUB, OP17_SLT, OP17_SLTU, OP17_AND, OP17_OR, OP17_NOR,
                     OP17_XOR, OP17_SLL, OP17_SRL, OP17_SRA, OP17_SLLI, OP17_SRLI, OP17_SRAI};
        ri12_ops = '{OP10_ADDI, OP10_SLTI, OP10_SLTUI, OP10_ANDI, OP10_ORI, OP10_XORI};
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Quiet window before traffic
        repeat (8) @(posedge clk);

        cycles = 0;
        while (sent < N_INSTR && cycles < SEND_LIMIT) begin
            run_cycle(1'b1);
            cycles++;
        end
        if (sent < N_INSTR) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d words were sent", sent, N_INSTR);
        end

        if (!timed_out) begin
            cycles = 0;
            do begin
                run_cycle(1'b0);
                cycles++;
            end while (pending != 0 && cycles < DRAIN_LIMIT);
            if (pending != 0) begin
                timed_out = 1'b1;
                $display("Timeout: %0d results never came back", pending);
            end
        end

        if (!timed_out) begin
            in_valid   = 1'b0;
            res_credit = 1'b0;
            end_test   = 1'b1;
            cycles     = 0;
            do begin
                @(posedge clk);
                #1;
                end_test = 1'b0;
                cycles++;
            end while (!checks_done && cycles < DONE_LIMIT);
            if (!checks_done) begin
                timed_out = 1'b1;
                $display("Timeout: the checker did not finish its final checks");
            end
        end

        $display("Results checked: %0d, value errors: %0d, protocol errors: %0d",
                 checked, value_errors, proto_errors);
        if (!timed_out && value_errors == 0 && proto_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/isa_pkg.sv
source/issue_ctrl.sv
source/inst_decode.sv
source/operand_fetch.sv
source/exec_alu.sv
source/exec_core.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_top -Mdir obj_dir -f vlog.f
./obj_dir/Vtb_top > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
